// ==== design/dfe_map_pkg.sv ====
// DFE register map of the reconfig controller: mode enum, Avalon addresses, offsets and data codes
package dfe_map_pkg;

    // host mode select, reserved behaves as continuous
    typedef enum logic [1:0] {
        mode_off        = 2'd0,
        mode_one_time   = 2'd1,
        mode_continuous = 2'd2,
        mode_reserved   = 2'd3
    } dfe_mode_e;

    // controller addresses on the management bus
    localparam logic [6:0] addr_lch    = 7'h28;  // logical channel
    localparam logic [6:0] addr_status = 7'h2A;  // control / status
    localparam logic [6:0] addr_offset = 7'h2B;  // DFE register offset
    localparam logic [6:0] addr_data   = 7'h2C;  // DFE register data

    // offsets inside the DFE block
    localparam logic [31:0] off_power    = 32'h0000_0000;  // power and adaptation enable
    localparam logic [31:0] off_vref     = 32'h0000_0006;  // vref field in bits 2:0
    localparam logic [31:0] off_one_time = 32'h0000_000B;  // one-time adaptation trigger

    // status register codes
    localparam logic [31:0] status_start_write = 32'd1;  // commit data latch to offset
    localparam logic [31:0] status_start_read  = 32'd2;  // load data latch from offset
    localparam int          status_busy_bit    = 8;      // set while the controller works

    // data words for offset 0x0
    localparam logic [31:0] mode_data_off        = 32'd0;
    localparam logic [31:0] mode_data_one_time   = 32'd2;
    localparam logic [31:0] mode_data_continuous = 32'd3;

    localparam logic [31:0] one_time_enable = 32'd1;  // written to offset 0xB

    localparam int vref_w = 3;  // vref field width

endpackage

// ==== design/dfe_bus_pkg.sv ====
// command and Avalon master types passed between the DFE sequencer, register port and top level
package dfe_bus_pkg;

    // what the register port does with one command
    typedef enum logic [1:0] {
        op_write,        // single Avalon write
        op_read,         // single Avalon read, data back on rd_data
        op_poll_status,  // read status until busy bit is clear
        op_wait_mgmt     // mgmt_busy high, then low
    } cmd_op_e;

    // one register command, 41 bits
    typedef struct packed {
        cmd_op_e     op;
        logic [6:0]  addr;
        logic [31:0] data;   // write data, zero for reads
    } reg_cmd_t;

    // Avalon-MM master outputs, 41 bits
    typedef struct packed {
        logic        write;
        logic        read;
        logic [6:0]  address;
        logic [31:0] writedata;
    } av_master_t;

endpackage

// ==== design/dfe_sequencer.sv ====
// DFE step sequencer, issues one register command per step for mode setup, trigger and vref override
`timescale 1ns/100ps

module dfe_sequencer #(
    parameter int lch_w = 32
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start,
    input  dfe_map_pkg::dfe_mode_e           mode,
    input  logic                             vref_en,
    input  logic [dfe_map_pkg::vref_w-1:0]   vref_low,
    input  logic [dfe_map_pkg::vref_w-1:0]   vref_high,
    input  logic [lch_w-1:0]                 lch,
    input  logic                             mgmt_busy,
    output dfe_bus_pkg::reg_cmd_t            cmd,
    output logic                             cmd_valid,
    input  logic                             cmd_done,
    input  logic [31:0]                      rd_data,
    output logic                             busy
);

    typedef enum logic [4:0] {
        st_idle,
        st_lch,                                               // channel select
        st_pwr_off, st_pwr_data, st_pwr_go, st_pwr_poll,      // off / continuous
        st_trig_off, st_trig_data, st_trig_go, st_trig_wait,  // one-time trigger
        st_vref_off_rd, st_vref_rd_go, st_vref_rd_wait, st_vref_rd_data,
        st_vref_off_wr, st_vref_data, st_vref_wr_go, st_vref_wr_wait,
        st_finish                                             // hold busy until start drops
    } seq_state_e;

    seq_state_e                       state, nxt;
    logic                             issue;        // drives cmd_valid
    logic                             hi_pass;      // second vref pass running
    dfe_map_pkg::dfe_mode_e           mode_q;       // latched at start
    logic                             vref_en_q;
    logic [dfe_map_pkg::vref_w-1:0]   vref_low_q, vref_high_q;
    logic [31:0]                      vref_word;    // captured offset 0x6 word
    logic                             vref_run;
    logic                             accept;

    assign accept    = (state == st_idle) && start && !mgmt_busy;
    assign vref_run  = vref_en_q && (mode_q != dfe_map_pkg::mode_off);
    assign cmd_valid = issue;

    // step order, advanced on cmd_done
    always_comb begin
        nxt = state;
        case (state)
            st_lch: begin
                if (vref_run)
                    nxt = st_vref_off_rd;                      // vref pass comes first
                else if (mode_q == dfe_map_pkg::mode_one_time)
                    nxt = st_trig_off;
                else
                    nxt = st_pwr_off;                          // off, continuous, reserved
            end
            st_pwr_off:      nxt = st_pwr_data;
            st_pwr_data:     nxt = st_pwr_go;
            st_pwr_go:       nxt = st_pwr_poll;
            st_pwr_poll:     nxt = st_finish;
            st_trig_off:     nxt = st_trig_data;
            st_trig_data:    nxt = st_trig_go;
            st_trig_go:      nxt = st_trig_wait;
            st_trig_wait:    nxt = (vref_run && !hi_pass) ? st_vref_off_wr : st_finish;
            st_vref_off_rd:  nxt = st_vref_rd_go;
            st_vref_rd_go:   nxt = st_vref_rd_wait;
            st_vref_rd_wait: nxt = st_vref_rd_data;
            st_vref_rd_data: nxt = st_vref_off_wr;
            st_vref_off_wr:  nxt = st_vref_data;
            st_vref_data:    nxt = st_vref_wr_go;
            st_vref_wr_go:   nxt = st_vref_wr_wait;
            st_vref_wr_wait: nxt = st_trig_off;                // trigger after each vref write
            default:         nxt = state;
        endcase
    end

    // command for the current step
    always_comb begin
        cmd.op   = dfe_bus_pkg::op_write;
        cmd.addr = dfe_map_pkg::addr_status;
        cmd.data = 32'd0;
        case (state)
            st_lch: begin
                cmd.addr = dfe_map_pkg::addr_lch;
                cmd.data = 32'(lch);                           // zero extended
            end
            st_pwr_off: begin
                cmd.addr = dfe_map_pkg::addr_offset;
                cmd.data = dfe_map_pkg::off_power;
            end
            st_pwr_data: begin
                cmd.addr = dfe_map_pkg::addr_data;
                case (mode_q)
                    dfe_map_pkg::mode_off: cmd.data = dfe_map_pkg::mode_data_off;
                    default:               cmd.data = dfe_map_pkg::mode_data_continuous;
                endcase                                        // reserved acts as continuous
            end
            st_pwr_go, st_trig_go, st_vref_wr_go: cmd.data = dfe_map_pkg::status_start_write;
            st_pwr_poll: cmd.op = dfe_bus_pkg::op_poll_status;
            st_trig_off: begin
                cmd.addr = dfe_map_pkg::addr_offset;
                cmd.data = dfe_map_pkg::off_one_time;
            end
            st_trig_data: begin
                cmd.addr = dfe_map_pkg::addr_data;
                cmd.data = dfe_map_pkg::one_time_enable;
            end
            st_trig_wait, st_vref_rd_wait, st_vref_wr_wait: cmd.op = dfe_bus_pkg::op_wait_mgmt;
            st_vref_off_rd, st_vref_off_wr: begin
                cmd.addr = dfe_map_pkg::addr_offset;
                cmd.data = dfe_map_pkg::off_vref;
            end
            st_vref_rd_go: cmd.data = dfe_map_pkg::status_start_read;
            st_vref_rd_data: begin
                cmd.op   = dfe_bus_pkg::op_read;
                cmd.addr = dfe_map_pkg::addr_data;
            end
            st_vref_data: begin
                cmd.addr = dfe_map_pkg::addr_data;
                cmd.data = {vref_word[31:dfe_map_pkg::vref_w], hi_pass ? vref_high_q : vref_low_q};
            end
            default: cmd.addr = dfe_map_pkg::addr_status;     // idle / finish, not issued
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= st_idle;
            busy    <= 1'b0;
            issue   <= 1'b0;
            hi_pass <= 1'b0;
        end else begin
            issue <= 1'b0;  // pulse only
            case (state)
                st_idle: begin
                    if (accept) begin
                        busy    <= 1'b1;
                        hi_pass <= 1'b0;
                        state   <= st_lch;
                        issue   <= 1'b1;              // first command right away
                    end
                end
                st_finish: begin
                    if (!start) begin
                        busy  <= 1'b0;                // host released the request
                        state <= st_idle;
                    end
                end
                default: begin
                    if (cmd_done) begin
                        state <= nxt;
                        issue <= (nxt != st_finish);
                        if (state == st_trig_wait && vref_run)
                            hi_pass <= 1'b1;          // low pass done, high pass next
                    end
                end
            endcase
        end
    end

    // request fields and read-back word
    always_ff @(posedge clk) begin
        if (accept) begin
            mode_q      <= mode;
            vref_en_q   <= vref_en;
            vref_low_q  <= vref_low;
            vref_high_q <= vref_high;
        end
        if (state == st_vref_rd_data && cmd_done)
            vref_word <= rd_data;                     // offset 0x6 before override
    end

endmodule

// ==== design/dfe_reg_port.sv ====
// Avalon register port, runs one sequencer command at a time against the reconfig controller
`timescale 1ns/100ps

module dfe_reg_port (
    input  logic                    clk,
    input  logic                    reset,
    input  dfe_bus_pkg::reg_cmd_t   cmd,
    input  logic                    cmd_valid,
    output logic                    cmd_done,
    output logic [31:0]             rd_data,
    output dfe_bus_pkg::av_master_t av,
    input  logic [31:0]             av_readdata,
    input  logic                    av_waitrequest,
    input  logic                    mgmt_busy
);

    typedef enum logic [2:0] {
        st_idle,
        st_access,     // single write or read
        st_poll,       // status reads until busy bit clear
        st_wait_high,  // controller has not started yet
        st_wait_low    // controller working
    } port_state_e;

    port_state_e           state;
    dfe_bus_pkg::reg_cmd_t cmd_q;  // held for the whole access

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= st_idle;
            cmd_done <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (cmd_valid) begin
                        case (cmd.op)
                            dfe_bus_pkg::op_write,
                            dfe_bus_pkg::op_read:        state <= st_access;
                            dfe_bus_pkg::op_poll_status: state <= st_poll;
                            default:                     state <= st_wait_high;
                        endcase
                    end
                end
                st_access: begin
                    if (!av_waitrequest) begin   // slave took it
                        cmd_done <= 1'b1;
                        state    <= st_idle;
                    end
                end
                st_poll: begin
                    // keep reading while busy bit is set
                    if (!av_waitrequest && !av_readdata[dfe_map_pkg::status_busy_bit]) begin
                        cmd_done <= 1'b1;
                        state    <= st_idle;
                    end
                end
                st_wait_high: if (mgmt_busy) state <= st_wait_low;
                st_wait_low: begin
                    if (!mgmt_busy) begin
                        cmd_done <= 1'b1;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && cmd_valid)
            cmd_q <= cmd;
        if (av.read && !av_waitrequest)
            rd_data <= av_readdata;            // readdata valid on the accepting cycle
    end

    // bus outputs follow the held command, stable through waitrequest
    always_comb begin
        av.write     = (state == st_access) && (cmd_q.op == dfe_bus_pkg::op_write);
        av.read      = ((state == st_access) && (cmd_q.op == dfe_bus_pkg::op_read)) ||
                       (state == st_poll);
        av.address   = cmd_q.addr;
        av.writedata = cmd_q.data;
    end

endmodule

// ==== design/dfe_ctrl_top.sv ====
// DFE setup engine top level, joins the step sequencer to the Avalon register port
`timescale 1ns/100ps

module dfe_ctrl_top #(
    parameter int lch_w = 32  // logical channel width, up to 32
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start,          // host request level
    input  dfe_map_pkg::dfe_mode_e           mode,
    input  logic                             vref_en,        // vref override enable
    input  logic [dfe_map_pkg::vref_w-1:0]   vref_low,
    input  logic [dfe_map_pkg::vref_w-1:0]   vref_high,
    input  logic [lch_w-1:0]                 lch,
    input  logic                             mgmt_busy,      // reconfig controller busy
    output dfe_bus_pkg::av_master_t          av,
    input  logic [31:0]                      av_readdata,
    input  logic                             av_waitrequest,
    output logic                             busy            // handshake back to host
);

    dfe_bus_pkg::reg_cmd_t cmd;        // current register command
    logic                  cmd_valid;  // one-cycle issue pulse
    logic                  cmd_done;   // one-cycle completion pulse
    logic [31:0]           rd_data;    // data of last read

    // chooses the register commands
    dfe_sequencer #(
        .lch_w (lch_w)
    ) u_seq (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .mode      (mode),
        .vref_en   (vref_en),
        .vref_low  (vref_low),
        .vref_high (vref_high),
        .lch       (lch),
        .mgmt_busy (mgmt_busy),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_done  (cmd_done),
        .rd_data   (rd_data),
        .busy      (busy)
    );

    // runs them on the bus
    dfe_reg_port u_port (
        .clk            (clk),
        .reset          (reset),
        .cmd            (cmd),
        .cmd_valid      (cmd_valid),
        .cmd_done       (cmd_done),
        .rd_data        (rd_data),
        .av             (av),
        .av_readdata    (av_readdata),
        .av_waitrequest (av_waitrequest),
        .mgmt_busy      (mgmt_busy)
    );

endmodule

// ==== sim/tb_clock.sv ====
// testbench clock and reset source, 8 ns clock with reset held over the first 3 rising edges
`timescale 1ns/100ps

module tb_clock #(
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;  // drops right after the third edge
    end

endmodule

// ==== sim/tb_reconfig_model.sv ====
// behavioral reconfig controller for the DFE testbench, offset registers, random waitrequest, busy pulses
`timescale 1ns/100ps

module tb_reconfig_model (
    input  logic                    clk,
    input  logic                    reset,
    input  dfe_bus_pkg::av_master_t av,
    output logic [31:0]             av_readdata,
    output logic                    av_waitrequest,
    output logic                    mgmt_busy,
    input  logic                    preload_en,    // backdoor write into regs
    input  logic [3:0]              preload_off,
    input  logic [31:0]             preload_data
);

    logic [31:0] regs [16];      // DFE registers by offset
    logic [31:0] vref_log [16];  // offset 0x6 commits, in order
    logic [31:0] lch_reg;
    logic [31:0] data_q;         // data latch
    logic [3:0]  off_q;          // offset latch
    logic [3:0]  busy_cnt;
    logic [3:0]  vref_count;
    logic [7:0]  trig_count;     // commits to offset 0xB
    logic [15:0] lfsr;

    // fibonacci taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    assign mgmt_busy = (busy_cnt != 4'd0);

    always_comb begin
        av_readdata = data_q;
        case (av.address)
            dfe_map_pkg::addr_lch:    av_readdata = lch_reg;
            dfe_map_pkg::addr_offset: av_readdata = {28'd0, off_q};
            dfe_map_pkg::addr_status: begin
                av_readdata = '0;
                av_readdata[dfe_map_pkg::status_busy_bit] = mgmt_busy;  // busy flag only
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin : model_seq
        logic [15:0] s;
        logic [2:0]  len;
        if (reset) begin
            for (int i = 0; i < 16; i++)
                regs[i] <= {28'hDFE_0000, 4'(i)};  // fill follows the offset
            lch_reg        <= '0;
            data_q         <= '0;
            off_q          <= '0;
            busy_cnt       <= '0;
            vref_count     <= '0;
            trig_count     <= '0;
            av_waitrequest <= 1'b0;
            lfsr           <= 16'd51;
        end else begin
            s = lfsr_next(lfsr);
            av_waitrequest <= s[0];              // one bit per cycle
            if (busy_cnt != 4'd0)
                busy_cnt <= busy_cnt - 4'd1;
            if (preload_en)
                regs[preload_off] <= preload_data;
            if (av.write && !av_waitrequest) begin
                case (av.address)
                    dfe_map_pkg::addr_lch:    lch_reg <= av.writedata;
                    dfe_map_pkg::addr_offset: off_q   <= av.writedata[3:0];
                    dfe_map_pkg::addr_data:   data_q  <= av.writedata;
                    dfe_map_pkg::addr_status: begin
                        len = '0;
                        for (int k = 0; k < 3; k++) begin
                            s   = lfsr_next(s);
                            len = {len[1:0], s[0]};
                        end
                        busy_cnt <= 4'd4 + 4'(len);    // 4 to 11 cycles
                        if (av.writedata == dfe_map_pkg::status_start_write) begin
                            regs[off_q] <= data_q;
                            if (off_q == 4'h6) begin
                                vref_log[vref_count] <= data_q;
                                vref_count           <= vref_count + 4'd1;
                            end
                            if (off_q == 4'hB)
                                trig_count <= trig_count + 8'd1;
                        end else begin
                            data_q <= regs[off_q];     // start read fills the latch
                        end
                    end
                    default: ;
                endcase
            end
            lfsr <= s;
        end
    end

endmodule

// ==== sim/tb_top.sv ====
// DFE setup engine testbench, runs host requests against the controller model and checks the results
`timescale 1ns/100ps

module tb_top;

    logic                                 clk;
    logic                                 reset;
    logic                                 start;
    logic                                 vref_en;
    dfe_map_pkg::dfe_mode_e               mode;
    logic [dfe_map_pkg::vref_w-1:0]       vref_low;
    logic [dfe_map_pkg::vref_w-1:0]       vref_high;
    logic [31:0]                          lch;
    logic                                 ext_busy;     // fakes a busy controller
    logic                                 model_busy;
    logic                                 mgmt_busy;
    logic                                 busy;
    dfe_bus_pkg::av_master_t              av;
    dfe_bus_pkg::av_master_t              av_prev;
    logic                                 stall_prev;   // last negedge saw a stalled access
    logic [31:0]                          av_readdata;
    logic                                 av_waitrequest;
    logic                                 preload_en;
    logic [3:0]                           preload_off;
    logic [31:0]                          preload_data;
    logic [15:0]                          rnd;          // stimulus LFSR state

    assign mgmt_busy = model_busy | ext_busy;

    tb_clock clock0 (.clk(clk), .reset(reset));

    dfe_ctrl_top #(.lch_w(32)) dut0 (
        .clk(clk), .reset(reset), .start(start), .mode(mode), .vref_en(vref_en),
        .vref_low(vref_low), .vref_high(vref_high), .lch(lch), .mgmt_busy(mgmt_busy),
        .av(av), .av_readdata(av_readdata), .av_waitrequest(av_waitrequest), .busy(busy)
    );

    tb_reconfig_model model0 (
        .clk(clk), .reset(reset), .av(av), .av_readdata(av_readdata),
        .av_waitrequest(av_waitrequest), .mgmt_busy(model_busy), .preload_en(preload_en),
        .preload_off(preload_off), .preload_data(preload_data)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < count; i++) begin
            rnd = lfsr_next(rnd);
            v   = {v[30:0], rnd[0]};  // one step per bit
        end
    endtask

    task automatic stop_fail(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        stop_fail($sformatf("MISMATCH time=%0t signal=%s expected=0x%0h got=0x%0h",
                            $time, name, exp, got));
    endtask

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    // sequence is over once bus and controller stay idle for 16 cycles
    task automatic wait_quiet(input int limit);
        int quiet;
        int n;
        quiet = 0;
        n     = 0;
        while (quiet < 16 && n < limit) begin
            @(negedge clk);
            n++;
            if (av.write || av.read || mgmt_busy)
                quiet = 0;
            else
                quiet++;
        end
        if (quiet < 16)
            stop_fail("DFE sequence did not finish before the timeout");
    endtask

    task automatic preload(input logic [3:0] off, input logic [31:0] data);
        @(posedge clk);
        preload_en   <= 1'b1;
        preload_off  <= off;
        preload_data <= data;
        @(posedge clk);
        preload_en <= 1'b0;
    endtask

    // one host request with the start/busy handshake checked around it
    task automatic run_seq(input dfe_map_pkg::dfe_mode_e m, input logic ven,
                           input logic [2:0] lo, input logic [2:0] hi,
                           input logic [31:0] ch, input int hold);
        @(posedge clk);
        mode      <= m;
        vref_en   <= ven;
        vref_low  <= lo;
        vref_high <= hi;
        lch       <= ch;
        start     <= 1'b1;
        ext_busy  <= (hold != 0);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_eq("busy", 64'(busy), 64'd0);  // start refused while busy
        end
        if (hold != 0) begin
            @(posedge clk);
            ext_busy <= 1'b0;
        end
        @(negedge clk);
        check_eq("busy", 64'(busy), 64'd0);
        @(negedge clk);
        check_eq("busy", 64'(busy), 64'd1);      // edge after start is seen
        wait_quiet(2000);
        check_eq("busy", 64'(busy), 64'd1);      // start still high
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_eq("busy", 64'(busy), 64'd1);
        @(negedge clk);
        check_eq("busy", 64'(busy), 64'd0);
        check_eq("lch_reg", 64'(model0.lch_reg), 64'(ch));
    endtask

    task automatic vref_case(input dfe_map_pkg::dfe_mode_e m);
        logic [31:0] word;
        logic [31:0] lo;
        logic [31:0] hi;
        logic [31:0] ch;
        logic [3:0]  vc;
        logic [7:0]  tc;
        take_bits(32, word);
        take_bits(3, lo);
        take_bits(3, hi);
        take_bits(32, ch);
        preload(4'h6, word);
        vc = model0.vref_count;
        tc = model0.trig_count;
        run_seq(m, 1'b1, lo[2:0], hi[2:0], ch, 0);
        check_eq("vref_count", 64'(model0.vref_count), 64'(vc + 4'd2));
        check_eq("trig_count", 64'(model0.trig_count), 64'(tc + 8'd2));
        check_eq("vref low", 64'(model0.vref_log[vc]), 64'({word[31:3], lo[2:0]}));
        check_eq("vref high", 64'(model0.vref_log[vc + 4'd1]), 64'({word[31:3], hi[2:0]}));
    endtask

    // a stalled access must keep address and data
    always @(negedge clk) begin
        if (reset) begin
            stall_prev <= 1'b0;
        end else begin
            if (stall_prev)
                assert (av === av_prev) else report_mismatch("av", 64'(av), 64'(av_prev));
            av_prev    <= av;
            stall_prev <= (av.write || av.read) && av_waitrequest;
        end
    end

    initial begin
        logic [31:0] w;
        logic [7:0]  tc;
        logic [3:0]  vc;
        int          n;
        start        = 1'b0;
        mode         = dfe_map_pkg::mode_off;
        vref_en      = 1'b0;
        vref_low     = '0;
        vref_high    = '0;
        lch          = '0;
        ext_busy     = 1'b0;
        preload_en   = 1'b0;
        preload_off  = '0;
        preload_data = '0;
        rnd          = 16'd51;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (reset !== 1'b0 && n < 20);
        if (reset !== 1'b0)
            stop_fail("reset was never released");
        check_eq("busy", 64'(busy), 64'd0);
        check_eq("av.write", 64'(av.write), 64'd0);
        check_eq("av.read", 64'(av.read), 64'd0);
        take_bits(32, w);
        run_seq(dfe_map_pkg::mode_off, 1'b0, 3'd0, 3'd0, w, 6);  // held off by mgmt_busy
        check_eq("reg 0x0", 64'(model0.regs[0]), 64'd0);
        take_bits(32, w);
        run_seq(dfe_map_pkg::mode_continuous, 1'b0, 3'd0, 3'd0, w, 0);
        check_eq("reg 0x0", 64'(model0.regs[0]), 64'd3);
        vc = model0.vref_count;
        take_bits(32, w);
        run_seq(dfe_map_pkg::mode_off, 1'b1, 3'd5, 3'd2, w, 0);  // off skips vref
        check_eq("reg 0x0", 64'(model0.regs[0]), 64'd0);
        check_eq("vref_count", 64'(model0.vref_count), 64'(vc));
        take_bits(32, w);
        run_seq(dfe_map_pkg::mode_reserved, 1'b0, 3'd0, 3'd0, w, 0);
        check_eq("reg 0x0", 64'(model0.regs[0]), 64'd3);
        preload(4'hB, 32'd0);
        tc = model0.trig_count;
        take_bits(32, w);
        run_seq(dfe_map_pkg::mode_one_time, 1'b0, 3'd1, 3'd6, w, 0);
        check_eq("reg 0xB", 64'(model0.regs[11]), 64'd1);
        check_eq("trig_count", 64'(model0.trig_count), 64'(tc + 8'd1));
        vref_case(dfe_map_pkg::mode_one_time);
        vref_case(dfe_map_pkg::mode_continuous);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
design/dfe_map_pkg.sv
design/dfe_bus_pkg.sv
design/dfe_sequencer.sv
design/dfe_reg_port.sv
design/dfe_ctrl_top.sv
sim/tb_clock.sv
sim/tb_reconfig_model.sv
sim/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the DFE testbench with Verilator, exit status 1 on any failure

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f src.f -o sim_tb \
    > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
